// ==== logic/lsConsts.svh ====
`ifndef LS_CONSTS_SVH
`define LS_CONSTS_SVH

// buffer entries
`define LS_DEPTH 8

// rename tag width, tag 0 means no dependency
`define TAG_W 4

// data and address width
`define DATA_W 32

// data memory size in 32-bit words
`define MEM_WORDS 256

// request to response cycles
`define MEM_LATENCY 2

`endif

// ==== logic/lsPkg.sv ====
package lsPkg;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize;

    // I-type layout used by loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } loadFormat;

    // S-type layout used by stores
    typedef struct packed {
        logic [6:0] immHigh;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLow;
        logic [6:0] opcode;
    } storeFormat;

    typedef union packed {
        loadFormat  load;
        storeFormat store;
    } instrWord;

endpackage

// ==== logic/lsDecode.sv ====
`include "lsConsts.svh"

module lsDecode (
    input  lsPkg::instrWord      instr,
    output logic                 isLoad,
    output logic                 isStore,
    output lsPkg::accessSize     size,
    output logic                 isSigned,
    output logic [`DATA_W-1:0]   imm,
    output logic                 illegal
);

    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    always_comb begin
        isLoad   = 1'b0;
        isStore  = 1'b0;
        size     = lsPkg::sizeWord;
        isSigned = 1'b0;
        imm      = '0;
        // opcode sits in the same bits for both layouts
        case (instr.load.opcode)
            opLoad: begin
                imm = {{(`DATA_W-12){instr.load.imm[11]}}, instr.load.imm};
                isLoad = 1'b1;
                case (instr.load.funct3)
                    3'b000: begin
                        size     = lsPkg::sizeByte;
                        isSigned = 1'b1;
                    end
                    3'b001: begin
                        size     = lsPkg::sizeHalf;
                        isSigned = 1'b1;
                    end
                    3'b010: size = lsPkg::sizeWord;
                    3'b100: size = lsPkg::sizeByte;
                    3'b101: size = lsPkg::sizeHalf;
                    default: isLoad = 1'b0;
                endcase
            end
            opStore: begin
                imm = {{(`DATA_W-12){instr.store.immHigh[6]}},
                       instr.store.immHigh, instr.store.immLow};
                isStore = 1'b1;
                case (instr.store.funct3)
                    3'b000: size = lsPkg::sizeByte;
                    3'b001: size = lsPkg::sizeHalf;
                    3'b010: size = lsPkg::sizeWord;
                    default: isStore = 1'b0;
                endcase
            end
            default: ;
        endcase
        illegal = !(isLoad || isStore);
    end

endmodule

// ==== logic/lsBuffer.sv ====
`include "lsConsts.svh"

module lsBuffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispValid,
    input  logic [`TAG_W-1:0]     dispTag,
    input  logic [`TAG_W-1:0]     dispRs1Tag,
    input  logic [`DATA_W-1:0]    dispRs1Data,
    input  logic [`TAG_W-1:0]     dispRs2Tag,
    input  logic [`DATA_W-1:0]    dispRs2Data,
    input  logic                  decIsLoad,
    input  logic                  decIsStore,
    input  lsPkg::accessSize      decSize,
    input  logic                  decSigned,
    input  logic [`DATA_W-1:0]    decImm,
    input  logic                  decIllegal,
    input  logic                  wakeValid,
    input  logic [`TAG_W-1:0]     wakeTag,
    input  logic [`DATA_W-1:0]    wakeData,
    input  logic                  loopValid,
    input  logic [`TAG_W-1:0]     loopTag,
    input  logic [`DATA_W-1:0]    loopData,
    input  logic                  commitValid,
    input  logic [`TAG_W-1:0]     commitTag,
    input  logic                  freeValid,
    input  logic [`TAG_W-1:0]     freeTag,
    output logic                  memReqValid,
    output logic                  memReqStore,
    output lsPkg::accessSize      memReqSize,
    output logic                  memReqSigned,
    output logic [`DATA_W-1:0]    memReqAddr,
    output logic [`DATA_W-1:0]    memReqData,
    output logic [`TAG_W-1:0]     memReqTag
);

    localparam int idxW = $clog2(`LS_DEPTH);

    logic [`LS_DEPTH-1:0] occupied, issued, committed, src1Valid, src2Valid;
    logic [`LS_DEPTH-1:0] olderStores [`LS_DEPTH];
    logic [`LS_DEPTH-1:0] entStore, entSigned;
    lsPkg::accessSize     entSize  [`LS_DEPTH];
    logic [`TAG_W-1:0]    entTag   [`LS_DEPTH];
    logic [`TAG_W-1:0]    src1Tag  [`LS_DEPTH];
    logic [`TAG_W-1:0]    src2Tag  [`LS_DEPTH];
    logic [`DATA_W-1:0]   entImm   [`LS_DEPTH];
    logic [`DATA_W-1:0]   src1Data [`LS_DEPTH];
    logic [`DATA_W-1:0]   src2Data [`LS_DEPTH];

    logic [`LS_DEPTH-1:0] wake1Hit, loop1Hit, wake2Hit, loop2Hit;
    logic [`LS_DEPTH-1:0] commitHit, freeHit, storeReady, loadReady;
    logic [idxW-1:0]      allocIdx, issueIdx;
    logic                 allocate, issue;
    logic                 alloc1Valid, alloc2Valid;
    logic [`DATA_W-1:0]   alloc1Data, alloc2Data;

    function automatic logic [idxW-1:0] firstSet(input logic [`LS_DEPTH-1:0] v);
        logic [idxW-1:0] idx;
        idx = '0;
        for (int i = `LS_DEPTH - 1; i >= 0; i--) begin
            if (v[i]) idx = idxW'(i);
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < `LS_DEPTH; i++) begin
            wake1Hit[i]  = wakeValid && !src1Valid[i] && src1Tag[i] == wakeTag;
            loop1Hit[i]  = loopValid && !src1Valid[i] && src1Tag[i] == loopTag;
            wake2Hit[i]  = wakeValid && !src2Valid[i] && src2Tag[i] == wakeTag;
            loop2Hit[i]  = loopValid && !src2Valid[i] && src2Tag[i] == loopTag;
            commitHit[i] = commitValid && occupied[i] && entStore[i] && !issued[i]
                           && entTag[i] == commitTag;
            freeHit[i]   = freeValid && occupied[i] && issued[i] && entTag[i] == freeTag;
            // stores leave in program order
            storeReady[i] = occupied[i] && entStore[i] && !issued[i]
                            && (committed[i] || commitHit[i])
                            && src1Valid[i] && src2Valid[i]
                            && (olderStores[i] & ~issued) == '0;
            loadReady[i]  = occupied[i] && !entStore[i] && !issued[i]
                            && src1Valid[i] && olderStores[i] == '0;
        end
    end

    // operands broadcast in the dispatch cycle itself
    always_comb begin
        alloc1Valid = dispRs1Tag == '0;
        alloc1Data  = dispRs1Data;
        alloc2Valid = dispRs2Tag == '0;
        alloc2Data  = dispRs2Data;
        if (dispRs1Tag != '0 && wakeValid && dispRs1Tag == wakeTag) begin
            alloc1Valid = 1'b1;
            alloc1Data  = wakeData;
        end else if (dispRs1Tag != '0 && loopValid && dispRs1Tag == loopTag) begin
            alloc1Valid = 1'b1;
            alloc1Data  = loopData;
        end
        if (dispRs2Tag != '0 && wakeValid && dispRs2Tag == wakeTag) begin
            alloc2Valid = 1'b1;
            alloc2Data  = wakeData;
        end else if (dispRs2Tag != '0 && loopValid && dispRs2Tag == loopTag) begin
            alloc2Valid = 1'b1;
            alloc2Data  = loopData;
        end
    end

    assign allocate = dispValid && (decIsLoad || decIsStore) && !decIllegal;
    assign allocIdx = firstSet(~occupied);
    assign issue    = |storeReady || |loadReady;
    assign issueIdx = |storeReady ? firstSet(storeReady) : firstSet(loadReady);

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied    <= '0;
            issued      <= '0;
            committed   <= '0;
            memReqValid <= 1'b0;
        end else begin
            memReqValid <= issue;
            occupied    <= occupied & ~freeHit;
            committed   <= committed | commitHit;
            src1Valid   <= src1Valid | wake1Hit | loop1Hit;
            src2Valid   <= src2Valid | wake2Hit | loop2Hit;
            for (int i = 0; i < `LS_DEPTH; i++) begin
                olderStores[i] <= olderStores[i] & ~freeHit;
            end
            if (issue) begin
                issued[issueIdx] <= 1'b1;
            end
            if (allocate) begin
                occupied[allocIdx]    <= 1'b1;
                issued[allocIdx]      <= 1'b0;
                committed[allocIdx]   <= 1'b0;
                src1Valid[allocIdx]   <= alloc1Valid;
                src2Valid[allocIdx]   <= alloc2Valid;
                olderStores[allocIdx] <= occupied & entStore & ~freeHit;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LS_DEPTH; i++) begin
            if (wake1Hit[i]) src1Data[i] <= wakeData;
            else if (loop1Hit[i]) src1Data[i] <= loopData;
            if (wake2Hit[i]) src2Data[i] <= wakeData;
            else if (loop2Hit[i]) src2Data[i] <= loopData;
        end
        if (allocate) begin
            entStore[allocIdx]  <= decIsStore;
            entSize[allocIdx]   <= decSize;
            entSigned[allocIdx] <= decSigned;
            entTag[allocIdx]    <= dispTag;
            entImm[allocIdx]    <= decImm;
            src1Tag[allocIdx]   <= dispRs1Tag;
            src2Tag[allocIdx]   <= dispRs2Tag;
            src1Data[allocIdx]  <= alloc1Data;
            src2Data[allocIdx]  <= alloc2Data;
        end
        if (issue) begin
            memReqStore  <= entStore[issueIdx];
            memReqSize   <= entSize[issueIdx];
            memReqSigned <= entSigned[issueIdx];
            memReqTag    <= entTag[issueIdx];
            memReqAddr   <= src1Data[issueIdx] + entImm[issueIdx];
            memReqData   <= src2Data[issueIdx];
        end
    end

    // credits must keep the dispatcher off a full buffer
    noAllocWhenFull: assert property (@(posedge clk) disable iff (reset)
        dispValid |-> !(&occupied));

    commitOneStore: assert property (@(posedge clk) disable iff (reset)
        commitValid |-> $onehot(commitHit));

    freeIssuedEntry: assert property (@(posedge clk) disable iff (reset)
        freeValid |-> $onehot(freeHit));

endmodule

// ==== logic/lsMemory.sv ====
`include "lsConsts.svh"

module lsMemory (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reqValid,
    input  logic                 reqStore,
    input  lsPkg::accessSize     reqSize,
    input  logic                 reqSigned,
    input  logic [`DATA_W-1:0]   reqAddr,
    input  logic [`DATA_W-1:0]   reqData,
    input  logic [`TAG_W-1:0]    reqTag,
    output logic                 rspValid,
    output logic                 rspStore,
    output logic [`TAG_W-1:0]    rspTag,
    output lsPkg::accessSize     rspSize,
    output logic                 rspSigned,
    output logic [1:0]           rspByteOffset,
    output logic [`DATA_W-1:0]   rspWord
);

    localparam int idxW = $clog2(`MEM_WORDS);

    logic [`DATA_W-1:0] mem [`MEM_WORDS];

    logic                s1Valid, s1Store, s1Signed;
    logic [`TAG_W-1:0]   s1Tag;
    lsPkg::accessSize    s1Size;
    logic [1:0]          s1Offset;
    logic [idxW-1:0]     s1Index;
    logic [3:0]          s1ByteEn;
    logic [`DATA_W-1:0]  s1Data;
    logic [3:0]          byteEn;

    always_comb begin
        case (reqSize)
            lsPkg::sizeByte: byteEn = 4'b0001 << reqAddr[1:0];
            lsPkg::sizeHalf: byteEn = 4'b0011 << reqAddr[1:0];
            default:         byteEn = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid  <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            s1Valid  <= reqValid;
            rspValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1, lanes and index
        s1Store  <= reqStore;
        s1Signed <= reqSigned;
        s1Tag    <= reqTag;
        s1Size   <= reqSize;
        s1Offset <= reqAddr[1:0];
        s1Index  <= reqAddr[idxW+1:2];
        s1ByteEn <= byteEn;
        s1Data   <= reqData << {reqAddr[1:0], 3'b000};
        // stage 2, array access
        if (s1Valid && s1Store) begin
            for (int b = 0; b < 4; b++) begin
                if (s1ByteEn[b]) mem[s1Index][8*b +: 8] <= s1Data[8*b +: 8];
            end
        end
        rspWord       <= mem[s1Index];
        rspStore      <= s1Store;
        rspSigned     <= s1Signed;
        rspTag        <= s1Tag;
        rspSize       <= s1Size;
        rspByteOffset <= s1Offset;
    end

    naturalAlign: assert property (@(posedge clk) disable iff (reset)
        reqValid |-> (reqSize == lsPkg::sizeByte)
                  || (reqSize == lsPkg::sizeHalf && !reqAddr[0])
                  || (reqSize == lsPkg::sizeWord && reqAddr[1:0] == 2'b00));

endmodule

// ==== logic/lsResult.sv ====
`include "lsConsts.svh"

module lsResult (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rspValid,
    input  logic                 rspStore,
    input  logic [`TAG_W-1:0]    rspTag,
    input  lsPkg::accessSize     rspSize,
    input  logic                 rspSigned,
    input  logic [1:0]           rspByteOffset,
    input  logic [`DATA_W-1:0]   rspWord,
    input  logic                 illegal,
    output logic                 loadValid,
    output logic [`TAG_W-1:0]    loadTag,
    output logic [`DATA_W-1:0]   loadData,
    output logic                 storeDoneValid,
    output logic [`TAG_W-1:0]    storeDoneTag,
    output logic                 creditReturn,
    output logic                 freeValid,
    output logic [`TAG_W-1:0]    freeTag,
    output logic                 illegalOp
);

    logic [`DATA_W-1:0] shifted, extended;
    logic               creditPending;

    always_comb begin
        shifted = rspWord >> {rspByteOffset, 3'b000};
        case (rspSize)
            lsPkg::sizeByte:
                extended = {{(`DATA_W-8){rspSigned && shifted[7]}}, shifted[7:0]};
            lsPkg::sizeHalf:
                extended = {{(`DATA_W-16){rspSigned && shifted[15]}}, shifted[15:0]};
            default:
                extended = rspWord;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loadValid      <= 1'b0;
            storeDoneValid <= 1'b0;
            freeValid      <= 1'b0;
            illegalOp      <= 1'b0;
            creditReturn   <= 1'b0;
            creditPending  <= 1'b0;
        end else begin
            loadValid      <= rspValid && !rspStore;
            storeDoneValid <= rspValid && rspStore;
            freeValid      <= rspValid;
            illegalOp      <= illegal;
            // completion wins, an illegal credit waits one cycle
            creditReturn   <= rspValid || creditPending || illegal;
            creditPending  <= rspValid ? (creditPending || illegal)
                                       : (creditPending && illegal);
        end
    end

    always_ff @(posedge clk) begin
        loadTag      <= rspTag;
        loadData     <= extended;
        storeDoneTag <= rspTag;
        freeTag      <= rspTag;
    end

endmodule

// ==== logic/lsUnit.sv ====
`include "lsConsts.svh"

module lsUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispValid,
    input  lsPkg::instrWord      dispInstr,
    input  logic [`TAG_W-1:0]    dispTag,
    input  logic [`TAG_W-1:0]    dispRs1Tag,
    input  logic [`DATA_W-1:0]   dispRs1Data,
    input  logic [`TAG_W-1:0]    dispRs2Tag,
    input  logic [`DATA_W-1:0]   dispRs2Data,
    input  logic                 cdbValid,
    input  logic [`TAG_W-1:0]    cdbTag,
    input  logic [`DATA_W-1:0]   cdbData,
    input  logic                 commitValid,
    input  logic [`TAG_W-1:0]    commitTag,
    output logic                 loadValid,
    output logic [`TAG_W-1:0]    loadTag,
    output logic [`DATA_W-1:0]   loadData,
    output logic                 storeDoneValid,
    output logic [`TAG_W-1:0]    storeDoneTag,
    output logic                 creditReturn,
    output logic                 illegalOp
);

    logic                decIsLoad, decIsStore, decSigned, decIllegal;
    lsPkg::accessSize    decSize;
    logic [`DATA_W-1:0]  decImm;

    logic                memReqValid, memReqStore, memReqSigned;
    lsPkg::accessSize    memReqSize;
    logic [`DATA_W-1:0]  memReqAddr, memReqData;
    logic [`TAG_W-1:0]   memReqTag;

    logic                rspValid, rspStore, rspSigned;
    logic [`TAG_W-1:0]   rspTag;
    lsPkg::accessSize    rspSize;
    logic [1:0]          rspByteOffset;
    logic [`DATA_W-1:0]  rspWord;

    logic                freeValid;
    logic [`TAG_W-1:0]   freeTag;

    lsDecode i_lsDecode (
        .instr    (dispInstr),
        .isLoad   (decIsLoad),
        .isStore  (decIsStore),
        .size     (decSize),
        .isSigned (decSigned),
        .imm      (decImm),
        .illegal  (decIllegal)
    );

    // load results loop back as a second wakeup source
    lsBuffer i_lsBuffer (
        .clk, .reset,
        .dispValid, .dispTag, .dispRs1Tag, .dispRs1Data, .dispRs2Tag, .dispRs2Data,
        .decIsLoad, .decIsStore, .decSize, .decSigned, .decImm, .decIllegal,
        .wakeValid   (cdbValid),
        .wakeTag     (cdbTag),
        .wakeData    (cdbData),
        .loopValid   (loadValid),
        .loopTag     (loadTag),
        .loopData    (loadData),
        .commitValid, .commitTag, .freeValid, .freeTag,
        .memReqValid, .memReqStore, .memReqSize, .memReqSigned,
        .memReqAddr, .memReqData, .memReqTag
    );

    lsMemory i_lsMemory (
        .clk, .reset,
        .reqValid  (memReqValid),
        .reqStore  (memReqStore),
        .reqSize   (memReqSize),
        .reqSigned (memReqSigned),
        .reqAddr   (memReqAddr),
        .reqData   (memReqData),
        .reqTag    (memReqTag),
        .rspValid, .rspStore, .rspTag, .rspSize, .rspSigned, .rspByteOffset, .rspWord
    );

    lsResult i_lsResult (
        .clk, .reset,
        .rspValid, .rspStore, .rspTag, .rspSize, .rspSigned, .rspByteOffset, .rspWord,
        .illegal (dispValid && decIllegal),
        .loadValid, .loadTag, .loadData, .storeDoneValid, .storeDoneTag,
        .creditReturn, .freeValid, .freeTag, .illegalOp
    );

endmodule

// ==== dv/lsUnitChecks.svh ====
`ifndef LS_UNIT_CHECKS_SVH
`define LS_UNIT_CHECKS_SVH

int errors = 0;

// credits never exceed the buffer depth
creditBound: assert property (@(posedge clk) disable iff (reset)
    creditReturn |-> credits + 1 - int'(dispValid) <= `LS_DEPTH)
    else begin
        errors++;
        $display("ERROR %0t: credit return above buffer depth", $time);
    end

loadValue: assert property (@(posedge clk) disable iff (reset)
    loadValid |-> loadPend[loadTag] && loadData == expData[loadTag])
    else begin
        errors++;
        $display("ERROR %0t: load tag %0d data %h expected %h", $time,
                 loadTag, loadData, expData[loadTag]);
    end

// base operand must have been broadcast first
wakeBeforeLoad: assert property (@(posedge clk) disable iff (reset)
    loadValid |-> blockTag[loadTag] == 0)
    else begin
        errors++;
        $display("ERROR %0t: load tag %0d ran before its base", $time, loadTag);
    end

storeOrder: assert property (@(posedge clk) disable iff (reset)
    storeDoneValid |-> storeDoneTag == commitOrder[doneRd])
    else begin
        errors++;
        $display("ERROR %0t: store done tag %0d out of commit order", $time,
                 storeDoneTag);
    end

idleLatency: assert property (@(posedge clk) disable iff (reset)
    dispValid && latArm |-> ##5 (loadValid && loadTag == $past(dispTag, 5)))
    else begin
        errors++;
        $display("ERROR %0t: idle load latency is not 5 cycles", $time);
    end

illegalFlag: assert property (@(posedge clk) disable iff (reset)
    dispValid && illegalArm |=> illegalOp)
    else begin
        errors++;
        $display("ERROR %0t: illegalOp missing after illegal word", $time);
    end

illegalOnlyWhenDue: assert property (@(posedge clk) disable iff (reset)
    illegalOp |-> $past(dispValid && illegalArm))
    else begin
        errors++;
        $display("ERROR %0t: unexpected illegalOp", $time);
    end

illegalNoResult: assert property (@(posedge clk) disable iff (reset)
    !(loadValid && loadTag == illTag) && !(storeDoneValid && storeDoneTag == illTag))
    else begin
        errors++;
        $display("ERROR %0t: result for the illegal word's tag", $time);
    end

`endif

// ==== dv/lsUnitTb.sv ====
`include "lsConsts.svh"

module lsUnitTb;

    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opArith = 7'b0110011;
    localparam logic [3:0] illTag  = 4'd15;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic dispValid, cdbValid, commitValid;
    lsPkg::instrWord dispInstr;
    logic [`TAG_W-1:0] dispTag, dispRs1Tag, dispRs2Tag, cdbTag, commitTag;
    logic [`DATA_W-1:0] dispRs1Data, dispRs2Data, cdbData;
    logic loadValid, storeDoneValid, creditReturn, illegalOp;
    logic [`TAG_W-1:0] loadTag, storeDoneTag;
    logic [`DATA_W-1:0] loadData;

    integer seed = 32'h65a8;
    int credits = `LS_DEPTH;
    int cycles = 0;
    int loadsIssued = 0, loadsDone = 0, storesIssued = 0, storesDone = 0, illegals = 0;
    logic [7:0] refMem [0:1023];
    logic loadPend [16];
    logic [`DATA_W-1:0] expData [16];
    logic [`TAG_W-1:0] blockTag [16];
    logic [`TAG_W-1:0] commitOrder [64];
    logic [5:0] commitWr = '0, doneRd = '0;
    logic latArm = 1'b0, illegalArm = 1'b0;
    logic [2:0] loadF3 [5] = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};

    lsUnit i_lsUnit (.*);

    always #10 clk = !clk;

    `include "lsUnitChecks.svh"

    // mirror of credits, completions and wakeups
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (reset) credits <= `LS_DEPTH;
        else credits <= credits + int'(creditReturn) - int'(dispValid);
        if (loadValid) begin
            loadPend[loadTag] <= 1'b0;
            loadsDone <= loadsDone + 1;
        end
        if (storeDoneValid) begin
            storesDone <= storesDone + 1;
            doneRd <= doneRd + 1;
        end
        for (int t = 0; t < 16; t++) begin
            if (blockTag[t] != 0 && ((cdbValid && cdbTag == blockTag[t])
                    || (loadValid && loadTag == blockTag[t]))) blockTag[t] <= '0;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] refLoad(input logic [2:0] f3, input int a);
        logic [31:0] w;
        w = {refMem[(a + 3) % 1024], refMem[(a + 2) % 1024], refMem[(a + 1) % 1024],
             refMem[a]};
        case (f3)
            3'd0: return {{24{w[7]}}, w[7:0]};
            3'd4: return {24'd0, w[7:0]};
            3'd1: return {{16{w[15]}}, w[15:0]};
            3'd5: return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic lsPkg::instrWord makeWord(input logic [6:0] op, input logic [2:0] f3,
                                                 input logic [11:0] imm);
        lsPkg::instrWord w;
        w = '0;
        if (op == opStore) begin
            w.store.immHigh = imm[11:5];
            w.store.immLow  = imm[4:0];
            w.store.rs2     = 5'd2;
            w.store.rs1     = 5'd1;
            w.store.funct3  = f3;
            w.store.opcode  = op;
        end else begin
            w.load.imm    = imm;
            w.load.rs1    = 5'd1;
            w.load.funct3 = f3;
            w.load.rd     = 5'd3;
            w.load.opcode = op;
        end
        return w;
    endfunction

    task automatic dispatch(input lsPkg::instrWord w, input logic [3:0] tag,
                            input logic [3:0] t1, input logic [31:0] d1,
                            input logic [3:0] t2, input logic [31:0] d2);
        while (credits == 0) tick();
        dispValid   = 1'b1;
        dispInstr   = w;
        dispTag     = tag;
        dispRs1Tag  = t1;
        dispRs1Data = d1;
        dispRs2Tag  = t2;
        dispRs2Data = d2;
        tick();
        dispValid  = 1'b0;
        latArm     = 1'b0;
        illegalArm = 1'b0;
    endtask

    task automatic storeOp(input logic [2:0] f3, input int addr, input logic [31:0] data,
                           input logic [3:0] tag);
        int imm;
        imm = $random(seed) % 64;
        for (int b = 0; b < (1 << f3); b++) refMem[addr + b] = data[8*b +: 8];
        storesIssued++;
        dispatch(makeWord(opStore, f3, 12'(imm)), tag, '0, 32'(addr - imm), '0, data);
    endtask

    // baseVal is what the base takes once broadcast, a pending base carries stale data
    task automatic loadOp(input logic [2:0] f3, input int addr, input logic [3:0] tag,
                          input logic [3:0] baseTag, input int baseVal);
        expData[tag]  = refLoad(f3, addr);
        loadPend[tag] = 1'b1;
        blockTag[tag] = baseTag;
        loadsIssued++;
        dispatch(makeWord(opLoad, f3, 12'(addr - baseVal)), tag, baseTag,
                 (baseTag == '0) ? 32'(baseVal) : ~32'(baseVal), '0, '0);
    endtask

    // size and offset follow n, word and base are random
    task automatic randomLoad(input logic [3:0] tag, input int n);
        int sel;
        int addr;
        sel  = n % 5;
        addr = 4 * ($unsigned($random(seed)) % 16) + (n / 5) % 4;
        addr = addr & ~((1 << loadF3[sel][1:0]) - 1);
        loadOp(loadF3[sel], addr, tag, '0, addr - $random(seed) % 64);
    endtask

    task automatic commit(input logic [3:0] tag);
        commitOrder[commitWr] = tag;
        commitWr++;
        commitValid = 1'b1;
        commitTag   = tag;
        tick();
        commitValid = 1'b0;
    endtask

    task automatic cdbPulse(input logic [3:0] tag, input logic [31:0] data);
        cdbValid = 1'b1;
        cdbTag   = tag;
        cdbData  = data;
        tick();
        cdbValid = 1'b0;
    endtask

    task automatic waitIdle();
        while (loadsDone != loadsIssued || storesDone != storesIssued) tick();
    endtask

    initial begin
        while (cycles <= 40 * (loadsIssued + storesIssued + illegals) + 200) @(posedge clk);
        $display("timeout: the run did not finish within its cycle limit");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int f3;
        int addr;
        dispValid   = 0;
        dispInstr   = '0;
        dispTag     = '0;
        dispRs1Tag  = '0;
        dispRs1Data = '0;
        dispRs2Tag  = '0;
        dispRs2Data = '0;
        cdbValid    = 0;
        cdbTag      = '0;
        cdbData     = '0;
        commitValid = 0;
        commitTag   = '0;
        for (int t = 0; t < 16; t++) begin
            loadPend[t] = 1'b0;
            blockTag[t] = '0;
        end
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        // two full batches of word stores fill the buffer before any commit
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 8; i++) storeOp(3'd2, 32 * b + 4 * i, $random(seed), 4'(i + 1));
            for (int i = 0; i < 8; i++) commit(4'(i + 1));
            waitIdle();
        end
        storeOp(3'd2, 160, 32'd36, 4'd3);
        commit(4'd3);
        waitIdle();
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 8; i++) randomLoad(4'(i + 1), 8 * b + i);
            waitIdle();
        end
        // mixed sizes, loads stuck behind uncommitted stores
        repeat (3) begin
            for (int i = 0; i < 4; i++) begin
                f3   = $unsigned($random(seed)) % 3;
                // each store gets a word of its own
                addr = 16 * i + (($unsigned($random(seed)) % 16) & ~((1 << f3) - 1));
                storeOp(3'(f3), addr, $random(seed), 4'(i + 1));
                loadOp(3'd2, addr & ~3, 4'(i + 5), '0, 0);
            end
            repeat (3) tick();
            for (int i = 0; i < 4; i++) commit(4'(i + 1));
            waitIdle();
        end
        loadOp(3'd2, 12, 4'd1, 4'd12, 200);
        repeat (6) tick();
        cdbPulse(4'd12, 32'd200);
        loadOp(3'd2, 160, 4'd2, '0, 150);
        loadOp(3'd0, 36, 4'd4, 4'd2, 36);
        waitIdle();
        latArm = 1'b1;
        loadOp(3'd5, 18, 4'd6, '0, 10);
        waitIdle();
        illegalArm = 1'b1;
        illegals++;
        dispatch(makeWord(opArith, 3'd0, 12'd0), illTag, '0, '0, '0, '0);
        illegalArm = 1'b1;
        illegals++;
        dispatch(makeWord(opLoad, 3'd3, 12'd0), illTag, '0, '0, '0, '0);
        repeat (10) tick();
        waitIdle();
        if (credits != `LS_DEPTH) begin
            errors++;
            $display("ERROR %0t: credit counter %0d expected %0d", $time, credits,
                     `LS_DEPTH);
        end
        $display("checks finished: %0d errors, %0d loads, %0d stores, %0d illegal words",
                 errors, loadsDone, storesDone, illegals);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
+incdir+dv
logic/lsPkg.sv
logic/lsDecode.sv
logic/lsBuffer.sv
logic/lsMemory.sv
logic/lsResult.sv
logic/lsUnit.sv
dv/lsUnitTb.sv
